// ==== verilog.f ====
rtl/mipsPkg.sv
rtl/mipsAlu.sv
rtl/mipsControl.sv
rtl/mipsRegFile.sv
rtl/mipsPcUnit.sv
rtl/mipsCpu.sv
tests/mipsCpu_properties.sv
tests/mipsCpuTb.sv

// ==== Bender.yml ====
package:
  name: mipsCpu

sources:
  - rtl/mipsPkg.sv
  - rtl/mipsAlu.sv
  - rtl/mipsControl.sv
  - rtl/mipsRegFile.sv
  - rtl/mipsPcUnit.sv
  - rtl/mipsCpu.sv
  - target: test
    files:
      - tests/mipsCpu_properties.sv
      - tests/mipsCpuTb.sv

// ==== tests/mipsCpuTb.sv ====
module mipsCpuTb
    import mipsPkg::*;
;

    localparam logic [31:0] resetAddress = 32'hBFC00000;

    logic        clk;
    logic        reset;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] dataWriteData;
    logic        dataRead;
    logic        dataWrite;
    logic [31:0] dataReadData;

    logic [31:0] imem [512];
    logic [31:0] dmem [1024];
    string       testName [512];
    logic [8:0]  fetchIndex;
    int          progLen = 0;
    int          seed = 24;
    int          endHits = 0;
    string       section;
    logic [15:0] storeOffset = 16'h0100;
    logic [31:0] endAddr;

    // Instruction set model state
    logic [31:0] refRegs [32];
    logic [31:0] refMem [1024];
    logic [31:0] refPc;
    logic [31:0] refSlot;
    logic        refStoreValid;
    logic [31:0] refStoreAddr;
    logic [31:0] refStoreData;
    logic        refLoadValid;
    logic [31:0] refLoadAddr;

    functE  aluFns [7] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
    opcodeE immOps [6] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU};
    functE  shiftFns [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    int     shiftAmounts [4] = '{0, 1, 16, 31};

    mipsCpu #(
        .resetAddress (resetAddress)
    ) mipsCpu_i (
        .clk           (clk),
        .reset         (reset),
        .instrAddr     (instrAddr),
        .instr         (instr),
        .dataAddr      (dataAddr),
        .dataWriteData (dataWriteData),
        .dataRead      (dataRead),
        .dataWrite     (dataWrite),
        .dataReadData  (dataReadData)
    );

    always #50 clk = ~clk;

    assign fetchIndex   = 9'((instrAddr - resetAddress) >> 2);
    assign instr        = imem[fetchIndex];
    assign dataReadData = dmem[dataAddr[11:2]]; // Word indexed

    always @(posedge clk) begin
        if (dataWrite) begin
            dmem[dataAddr[11:2]] <= dataWriteData;
        end
    end

    function automatic logic [31:0] fillWord(int i);
        return (32'(i) * 32'h9E3779B1) ^ 32'h3C5A96E1;
    endfunction

    function automatic int randomBelow(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] addressOf(int idx);
        return resetAddress + 32'(idx) * 32'd4;
    endfunction

    function automatic logic [31:0] encodeR(functE fn, int rs, int rt, int rd, int sa);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic logic [31:0] encodeI(opcodeE op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] encodeJ(opcodeE op, logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(logic [31:0] word);
        imem[progLen]     = word;
        testName[progLen] = section;
        progLen++;
    endtask

    task automatic storeResult(int rt);
        emit(encodeI(OP_SW, 0, rt, storeOffset));
        storeOffset += 16'd4;
    endtask

    // Taken branch skips the instruction after the delay slot
    task automatic branchCase(opcodeE op, int rs, int rt);
        emit(encodeI(op, rs, rt, 16'd2));
        emit(encodeI(OP_ADDIU, 18, 18, 16'd1)); // Delay slot, always runs
        emit(encodeI(OP_ADDIU, 19, 19, 16'd1));
    endtask

    // Executes the instruction at refPc following the MIPS32 rules
    function automatic void refStep();
        logic [31:0] ins, a, b, immS, immZ, res, slotNext, seqPc;
        logic [5:0]  op, fn;
        logic [4:0]  rs, rt, rd, sa, dst;
        logic        wr;
        ins  = imem[9'((refPc - resetAddress) >> 2)];
        op   = ins[31:26];
        fn   = ins[5:0];
        rs   = ins[25:21];
        rt   = ins[20:16];
        rd   = ins[15:11];
        sa   = ins[10:6];
        a    = refRegs[rs];
        b    = refRegs[rt];
        immS = {{16{ins[15]}}, ins[15:0]};
        immZ = {16'd0, ins[15:0]};
        res  = 32'd0;
        wr   = 1'b1;
        dst  = rt;
        seqPc         = refPc + 32'd4;
        slotNext      = refSlot + 32'd4;
        refStoreValid = 1'b0;
        refLoadValid  = 1'b0;
        case (op)
            OP_SPECIAL: begin
                dst = rd;
                case (fn)
                    FN_SLL:  res = b << sa;
                    FN_SRL:  res = b >> sa;
                    FN_SRA:  res = $signed(b) >>> sa;
                    FN_SLLV: res = b << a[4:0];
                    FN_SRLV: res = b >> a[4:0];
                    FN_SRAV: res = $signed(b) >>> a[4:0];
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
                    FN_SLTU: res = {31'd0, a < b};
                    FN_JALR: begin
                        res      = refPc + 32'd8;
                        slotNext = a;
                    end
                    FN_JR: begin
                        wr       = 1'b0;
                        slotNext = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + immS;
            OP_SLTI:  res = {31'd0, $signed(a) < $signed(immS)};
            OP_SLTIU: res = {31'd0, a < immS};
            OP_ANDI:  res = a & immZ;
            OP_ORI:   res = a | immZ;
            OP_XORI:  res = a ^ immZ;
            OP_LUI:   res = {ins[15:0], 16'd0};
            OP_LW: begin
                refLoadValid = 1'b1;
                refLoadAddr  = a + immS;
                res          = refMem[(a + immS) >> 2 & 32'h3FF];
            end
            OP_JAL: begin
                res      = refPc + 32'd8;
                dst      = 5'd31;
                slotNext = {seqPc[31:28], ins[25:0], 2'b00};
            end
            default: begin
                wr = 1'b0;
                if (op == OP_SW) begin
                    refStoreValid = 1'b1;
                    refStoreAddr  = a + immS;
                    refStoreData  = b;
                    refMem[(a + immS) >> 2 & 32'h3FF] = b;
                end else if (op == OP_J) begin
                    slotNext = {seqPc[31:28], ins[25:0], 2'b00};
                end else if ((op == OP_BEQ && a == b) || (op == OP_BNE && a != b)
                        || (op == OP_BLEZ && $signed(a) <= 0) || (op == OP_BGTZ && $signed(a) > 0)
                        || (op == OP_REGIMM && rt == 5'd0 && a[31])
                        || (op == OP_REGIMM && rt == 5'd1 && !a[31])) begin
                    slotNext = seqPc + (immS << 2);
                end
            end
        endcase
        if (wr && dst != 5'd0) begin
            refRegs[dst] = res;
        end
        refPc   = refSlot;
        refSlot = slotNext;
    endfunction

    task automatic stopRun();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic checkAddr(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: instrAddr expected %h actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkStore(string name, logic expWrite, logic [31:0] expAddr,
                              logic [31:0] expData, logic actWrite, logic [31:0] actAddr,
                              logic [31:0] actData);
        if (actWrite !== expWrite) begin
            $display("Fail %s: dataWrite expected %b actual %b", name, expWrite, actWrite);
            stopRun();
        end else if (expWrite && actAddr !== expAddr) begin
            $display("Fail %s: dataAddr expected %h actual %h", name, expAddr, actAddr);
            stopRun();
        end else if (expWrite && actData !== expData) begin
            $display("Fail %s: dataWriteData expected %h actual %h", name, expData, actData);
            stopRun();
        end
    endtask

    task automatic checkLoad(string name, logic expRead, logic [31:0] expAddr,
                             logic actRead, logic [31:0] actAddr);
        if (actRead !== expRead) begin
            $display("Fail %s: dataRead expected %b actual %b", name, expRead, actRead);
            stopRun();
        end else if (expRead && actAddr !== expAddr) begin
            $display("Fail %s: load dataAddr expected %h actual %h", name, expAddr, actAddr);
            stopRun();
        end
    endtask

    initial begin : buildProgram
        int          kind;
        int          base;
        logic [31:0] target;
        clk   = 1'b0;
        reset = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            dmem[i]   = fillWord(i);
            refMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'd0;
        end
        refPc   = resetAddress;
        refSlot = resetAddress + 32'd4;

        section = "setup";
        for (int r = 1; r <= 8; r++) begin
            emit(encodeI(OP_LUI, 0, r, 16'($random(seed))));
            emit(encodeI(OP_ORI, r, r, 16'($random(seed))));
        end
        section = "alu";
        for (int i = 0; i < 30; i++) begin
            kind = randomBelow(14);
            base = 1 + randomBelow(8); // Destination register
            if (kind < 7) begin
                emit(encodeR(aluFns[kind], 1 + randomBelow(8), 1 + randomBelow(8), base, 0));
            end else if (kind == 13) begin
                emit(encodeI(OP_LUI, 0, base, 16'($random(seed))));
            end else begin
                emit(encodeI(immOps[kind - 7], 1 + randomBelow(8), base, 16'($random(seed))));
            end
            storeResult(base);
        end

        section = "shifts";
        emit(encodeI(OP_LUI, 0, 9, 16'h8765)); // Negative operand
        emit(encodeI(OP_ORI, 9, 9, 16'h4321));
        foreach (shiftAmounts[n]) begin
            emit(encodeI(OP_ADDIU, 0, 10, 16'(96 + shiftAmounts[n]))); // Upper bits ignored
            for (int k = 0; k < 6; k++) begin
                emit(encodeR(shiftFns[k], k < 3 ? 0 : 10, 9, 11, k < 3 ? shiftAmounts[n] : 0));
                storeResult(11);
            end
        end

        section = "loads";
        emit(encodeI(OP_ADDIU, 0, 12, 16'h0800));
        for (int k = 0; k < 4; k++) begin
            emit(encodeI(OP_LW, 12, 13, 16'(4 * k)));
            emit(encodeR(FN_ADDU, 13, 12, 14, 0));
            storeResult(14);
        end
        emit(encodeI(OP_ADDIU, 0, 12, 16'h0820));
        emit(encodeI(OP_LW, 12, 13, 16'hFFFC));
        storeResult(13);

        section = "branches";
        emit(encodeI(OP_ADDIU, 0, 15, 16'd5));
        emit(encodeI(OP_ADDIU, 0, 16, 16'hFFFD));
        emit(encodeI(OP_ADDIU, 0, 17, 16'd0));
        branchCase(OP_BEQ, 15, 15);
        branchCase(OP_BEQ, 15, 16);
        branchCase(OP_BNE, 15, 16);
        branchCase(OP_BNE, 15, 15);
        branchCase(OP_BLEZ, 16, 0);
        branchCase(OP_BLEZ, 17, 0);
        branchCase(OP_BLEZ, 15, 0);
        branchCase(OP_BGTZ, 15, 0);
        branchCase(OP_BGTZ, 17, 0);
        branchCase(OP_REGIMM, 16, RI_BLTZ);
        branchCase(OP_REGIMM, 17, RI_BLTZ);
        branchCase(OP_REGIMM, 17, RI_BGEZ);
        branchCase(OP_REGIMM, 16, RI_BGEZ);
        storeResult(18);
        storeResult(19);

        section = "jumps";
        base = progLen;
        emit(encodeJ(OP_JAL, addressOf(base + 4)));
        emit(32'd0);
        emit(encodeJ(OP_J, addressOf(base + 7))); // Return point
        emit(32'd0);
        storeResult(31); // Subroutine body
        emit(encodeR(FN_JR, 31, 0, 0, 0));
        emit(32'd0);
        target = addressOf(base + 13);
        emit(encodeI(OP_LUI, 0, 20, target[31:16]));
        emit(encodeI(OP_ORI, 20, 20, target[15:0]));
        emit(encodeR(FN_JALR, 20, 0, 21, 0));
        emit(32'd0);
        emit(encodeI(OP_ADDIU, 19, 19, 16'd1));
        emit(encodeI(OP_ADDIU, 19, 19, 16'd1));
        storeResult(21);

        section = "end";
        endAddr = addressOf(progLen);
        emit(encodeJ(OP_J, endAddr));
        emit(32'd0);

        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

    always @(negedge clk) begin : compare
        int unsigned idx;
        if (mipsCpu_i.mipsCpuProperties_i.failures != 0) begin
            $display("Error: an assertion on the core's memory port or PC failed");
            stopRun();
        end else if (!reset) begin
            idx = (refPc - resetAddress) >> 2;
            checkAddr(testName[idx], refPc, instrAddr);
            if (refPc == endAddr) begin
                endHits++;
            end
            // Second visit proves the end loop and its delay slot
            if (endHits == 2) begin
                $display("SIMULATION PASSED");
                $finish;
            end else begin
                refStep();
                checkStore(testName[idx], refStoreValid, refStoreAddr, refStoreData,
                           dataWrite, dataAddr, dataWriteData);
                checkLoad(testName[idx], refLoadValid, refLoadAddr, dataRead, dataAddr);
            end
        end
    end

    initial begin : watchdog
        wait (reset === 1'b0);
        #((progLen + 20) * 100);
        $display("Error: the core never reached the end loop within %0d cycles", progLen + 20);
        stopRun();
    end

endmodule

// ==== tests/mipsCpu_properties.sv ====
module mipsCpuProperties #(
    parameter logic [31:0] resetAddress = 32'hBFC00000
) (
    input logic        clk,
    input logic        reset,
    input logic [31:0] instrAddr,
    input logic        dataRead,
    input logic        dataWrite
);

    int failures = 0; // Count of failed assertions

    noDualAccess: assert property (
        @(posedge clk) disable iff (reset) !(dataRead && dataWrite)
    ) else begin
        $error("data read and data write strobes are high together");
        failures++;
    end

    fetchAligned: assert property (
        @(posedge clk) disable iff (reset) instrAddr[1:0] == 2'b00
    ) else begin
        $error("instrAddr %h is not word aligned", instrAddr);
        failures++;
    end

    // First reset edge loads the PC, so the check starts one edge later
    resetHoldsPc: assert property (
        @(posedge clk) reset ##1 reset |-> instrAddr == resetAddress
    ) else begin
        $error("instrAddr %h differs from the reset address during reset", instrAddr);
        failures++;
    end

    resetNoWrite: assert property (
        @(posedge clk) reset |-> !dataWrite
    ) else begin
        $error("data write strobe is high during reset");
        failures++;
    end

endmodule

bind mipsCpu mipsCpuProperties #(.resetAddress(resetAddress)) mipsCpuProperties_i (.*);

// ==== rtl/mipsCpu.sv ====
module mipsCpu
    import mipsPkg::*;
#(
    parameter logic [31:0] resetAddress = 32'hBFC00000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWriteData,
    output logic        dataRead,
    output logic        dataWrite,
    input  logic [31:0] dataReadData
);

    regDstE      regDst;
    pcSelE       pcSel;
    memToRegE    memToReg;
    aluOpE       aluOp;
    logic [4:0]  shamt;
    logic        memRead;
    logic        memWrite;
    logic        aluSrc;
    logic        regWrite;

    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] aluResult;
    logic        aluCond;
    logic [31:0] linkAddr;

    opcodeE      op;
    logic        zeroExtend;
    logic [31:0] immExt;
    logic [31:0] aluB;
    logic [4:0]  writeAddr;
    logic [31:0] writeData;

    assign op = opcodeE'(instr[31:26]);

    // Logical immediates are zero extended
    assign zeroExtend = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
    assign immExt     = zeroExtend ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign aluB       = aluSrc ? immExt : rtData;

    always_comb begin
        case (regDst)
            DST_RD:     writeAddr = instr[15:11];
            DST_LINK31: writeAddr = 5'd31;
            default:    writeAddr = instr[20:16];
        endcase
    end

    always_comb begin
        case (memToReg)
            WB_MEM:  writeData = dataReadData;
            WB_LINK: writeData = linkAddr; // Return address PC+8
            default: writeData = aluResult;
        endcase
    end

    assign dataAddr      = aluResult;
    assign dataWriteData = rtData;
    assign dataRead      = memRead && !reset;
    assign dataWrite     = memWrite && !reset;

    mipsControl mipsControl_i (
        .instr    (instr),
        .aluCond  (aluCond),
        .regDst   (regDst),
        .pcSel    (pcSel),
        .memToReg (memToReg),
        .aluOp    (aluOp),
        .shamt    (shamt),
        .memRead  (memRead),
        .memWrite (memWrite),
        .aluSrc   (aluSrc),
        .regWrite (regWrite)
    );

    mipsRegFile mipsRegFile_i (
        .clk         (clk),
        .reset       (reset),
        .rsAddr      (instr[25:21]),
        .rtAddr      (instr[20:16]),
        .writeAddr   (writeAddr),
        .writeEnable (regWrite && !reset),
        .writeData   (writeData),
        .rsData      (rsData),
        .rtData      (rtData)
    );

    mipsAlu mipsAlu_i (
        .aluOp   (aluOp),
        .a       (rsData),
        .b       (aluB),
        .shamt   (shamt),
        .result  (aluResult),
        .aluCond (aluCond)
    );

    mipsPcUnit #(
        .resetAddress (resetAddress)
    ) mipsPcUnit_i (
        .clk       (clk),
        .reset     (reset),
        .pcSel     (pcSel),
        .offset    (instr[15:0]),
        .jumpIndex (instr[25:0]),
        .jumpReg   (rsData),
        .pc        (instrAddr),
        .linkAddr  (linkAddr)
    );

endmodule

// ==== rtl/mipsPcUnit.sv ====
module mipsPcUnit
    import mipsPkg::*;
#(
    parameter logic [31:0] resetAddress = 32'hBFC00000
) (
    input  logic        clk,
    input  logic        reset,
    input  pcSelE       pcSel,
    input  logic [15:0] offset,
    input  logic [25:0] jumpIndex,
    input  logic [31:0] jumpReg,
    output logic [31:0] pc,
    output logic [31:0] linkAddr
);

    logic [31:0] slotPc; // Address of the delay-slot instruction
    logic [31:0] slotNext;
    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;

    assign pcPlus4      = pc + 32'd4;
    assign linkAddr     = pc + 32'd8;
    assign branchTarget = pcPlus4 + {{14{offset[15]}}, offset, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00}; // Same 256 MB region

    always_comb begin
        case (pcSel)
            PC_BRANCH: slotNext = branchTarget;
            PC_JUMP:   slotNext = jumpTarget;
            PC_JREG:   slotNext = jumpReg;
            // Equals pc+8 except right after a redirect
            default:   slotNext = slotPc + 32'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= resetAddress;
            slotPc <= resetAddress + 32'd4;
        end else begin
            pc     <= slotPc;
            slotPc <= slotNext;
        end
    end

endmodule

// ==== rtl/mipsRegFile.sv ====
module mipsRegFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  writeAddr,
    input  logic        writeEnable,
    input  logic [31:0] writeData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData; // $zero never written
        end
    end

    // Combinational reads with $zero forced
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

// ==== rtl/mipsControl.sv ====
module mipsControl
    import mipsPkg::*;
(
    input  logic [31:0] instr,
    input  logic        aluCond,
    output regDstE      regDst,
    output pcSelE       pcSel,
    output memToRegE    memToReg,
    output aluOpE       aluOp,
    output logic [4:0]  shamt,
    output logic        memRead,
    output logic        memWrite,
    output logic        aluSrc,
    output logic        regWrite
);

    opcodeE op;
    functE  funct;
    regimmE rt;

    assign op    = opcodeE'(instr[31:26]);
    assign funct = functE'(instr[5:0]);
    assign rt    = regimmE'(instr[20:16]);

    always_comb begin
        // Safe defaults cover every undefined encoding
        regDst   = DST_RT;
        pcSel    = PC_SEQ;
        memToReg = WB_ALU;
        aluOp    = ALU_ADD;
        shamt    = 5'd0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regWrite = 1'b0;

        case (op)
            OP_SPECIAL: begin
                regDst   = DST_RD;
                regWrite = 1'b1;
                case (funct)
                    FN_SLL: begin
                        aluOp = ALU_SLL;
                        shamt = instr[10:6]; // Shift amount from instruction
                    end
                    FN_SRL: begin
                        aluOp = ALU_SRL;
                        shamt = instr[10:6];
                    end
                    FN_SRA: begin
                        aluOp = ALU_SRA;
                        shamt = instr[10:6];
                    end
                    FN_SLLV: aluOp = ALU_SLLV;
                    FN_SRLV: aluOp = ALU_SRLV;
                    FN_SRAV: aluOp = ALU_SRAV;
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_JR: begin
                        pcSel    = PC_JREG;
                        regWrite = 1'b0; // Plain register jump
                    end
                    FN_JALR: begin
                        pcSel    = PC_JREG;
                        memToReg = WB_LINK; // rd gets PC+8
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                case (rt)
                    RI_BLTZ: begin
                        aluOp = ALU_LES;
                        pcSel = aluCond ? PC_BRANCH : PC_SEQ;
                    end
                    RI_BGEZ: begin
                        aluOp = ALU_GEQ;
                        pcSel = aluCond ? PC_BRANCH : PC_SEQ;
                    end
                    default: pcSel = PC_SEQ;
                endcase
            end
            OP_J: pcSel = PC_JUMP;
            OP_JAL: begin
                pcSel    = PC_JUMP;
                regDst   = DST_LINK31; // Link register
                memToReg = WB_LINK;
                regWrite = 1'b1;
            end
            OP_BEQ: begin
                aluOp = ALU_EQ; // Compares rs against rt
                pcSel = aluCond ? PC_BRANCH : PC_SEQ;
            end
            OP_BNE: begin
                aluOp = ALU_NEQ;
                pcSel = aluCond ? PC_BRANCH : PC_SEQ;
            end
            OP_BLEZ: begin
                aluOp = ALU_LEQ;
                pcSel = aluCond ? PC_BRANCH : PC_SEQ;
            end
            OP_BGTZ: begin
                aluOp = ALU_GRT;
                pcSel = aluCond ? PC_BRANCH : PC_SEQ;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                case (op)
                    OP_SLTI:  aluOp = ALU_SLT;
                    OP_SLTIU: aluOp = ALU_SLTU;
                    OP_ANDI:  aluOp = ALU_AND;
                    OP_ORI:   aluOp = ALU_OR;
                    OP_XORI:  aluOp = ALU_XOR;
                    default:  aluOp = ALU_ADD;
                endcase
            end
            OP_LUI: begin
                aluOp    = ALU_SLL; // Immediate shifted up by 16
                shamt    = 5'd16;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            OP_LW: begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = WB_MEM;
                regWrite = 1'b1;
            end
            OP_SW: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            default: regWrite = 1'b0;
        endcase
    end

endmodule

// ==== rtl/mipsAlu.sv ====
module mipsAlu
    import mipsPkg::*;
(
    input  aluOpE       aluOp,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    output logic [31:0] result,
    output logic        aluCond
);

    logic signed [31:0] aSigned;
    logic signed [31:0] bSigned;
    logic               aIsZero;

    assign aSigned = a;
    assign bSigned = b;
    assign aIsZero = (a == 32'd0);

    always_comb begin
        result  = 32'd0;
        aluCond = 1'b0;

        case (aluOp)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = b << shamt;
            ALU_SLLV: result = b << a[4:0]; // Low five bits of rs
            ALU_SRL:  result = b >> shamt;
            ALU_SRLV: result = b >> a[4:0];
            ALU_SRA:  result = bSigned >>> shamt;
            ALU_SRAV: result = bSigned >>> a[4:0];
            ALU_SLT:  result = {31'd0, aSigned < bSigned};
            ALU_SLTU: result = {31'd0, a < b};

            // Branch conditions against zero only look at rs
            ALU_EQ:   aluCond = (a == b);
            ALU_NEQ:  aluCond = (a != b);
            ALU_LES:  aluCond = a[31];
            ALU_LEQ:  aluCond = a[31] || aIsZero;
            ALU_GRT:  aluCond = !a[31] && !aIsZero;
            ALU_GEQ:  aluCond = !a[31];
            default: begin
                result  = 32'd0;
                aluCond = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/mipsPkg.sv ====
package mipsPkg;

    // Primary opcode field instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,
        OP_REGIMM  = 6'd1,
        OP_J       = 6'd2,
        OP_JAL     = 6'd3,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_BLEZ    = 6'd6,
        OP_BGTZ    = 6'd7,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_SLTIU   = 6'd11,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcodeE;

    // Function field instr[5:0] under SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_JALR = 6'd9,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functE;

    // The rt field selects the branch under REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ = 5'd0,
        RI_BGEZ = 5'd1
    } regimmE;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_XOR  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SLLV = 5'd8,
        ALU_SRL  = 5'd9,
        ALU_SRLV = 5'd10,
        ALU_SRA  = 5'd11,
        ALU_SRAV = 5'd12,
        ALU_EQ   = 5'd13,
        ALU_LES  = 5'd14,
        ALU_LEQ  = 5'd15,
        ALU_GRT  = 5'd16,
        ALU_GEQ  = 5'd17,
        ALU_NEQ  = 5'd18,
        ALU_SLT  = 5'd20,
        ALU_SLTU = 5'd21
    } aluOpE;

    typedef enum logic [1:0] {
        DST_RT     = 2'd0,
        DST_RD     = 2'd1,
        DST_LINK31 = 2'd2
    } regDstE;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2,
        PC_JREG   = 2'd3
    } pcSelE;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } memToRegE;

endpackage
